/* list.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_axi_master.sv
rv_core.sv
rv_top.sv
rv_properties.sv
tb_rv_top.sv

/* run.sh */
#!/bin/sh
# build and run the rv_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_rv_top -f list.f -o tb_rv_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit $status
fi

./obj_dir/tb_rv_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

/* rv_alu.sv */
`timescale 1ns/1ns

module rv_alu (
  input  rv_pkg::funct3_t funct3,
  input  logic            alt,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (funct3)
      3'b000: result = alt ? a - b : a + b;
      3'b001: result = a << shamt;
      3'b010: result = {31'b0, $signed(a) < $signed(b)};
      3'b011: result = {31'b0, a < b};
      3'b100: result = a ^ b;
      3'b101: begin
        // arithmetic or logical right shift
        if (alt) begin
          result = $signed(a) >>> shamt;
        end else begin
          result = a >> shamt;
        end
      end
      3'b110: result = a | b;
      default: result = a & b;
    endcase
  end

endmodule

/* rv_axi_master.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_axi_master (
  input  logic              clk,
  input  logic              reset,
  // request from the core
  input  logic              req,
  input  logic              write,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::prot_t     prot,
  input  rv_pkg::word_t     cpu_wdata, // core store data
  input  rv_pkg::strb_t     cpu_wstrb,
  output logic              done,
  output logic              fault,
  output rv_pkg::word_t     rsp_data,
  // axi4-lite master
  output logic              awvalid,
  input  logic              awready,
  output rv_pkg::word_t     awaddr,
  output rv_pkg::prot_t     awprot,
  output logic              wvalid,
  input  logic              wready,
  output rv_pkg::word_t     wdata,
  output rv_pkg::strb_t     wstrb,
  input  logic              bvalid,
  output logic              bready,
  input  rv_pkg::resp_t     bresp,
  output logic              arvalid,
  input  logic              arready,
  output rv_pkg::word_t     araddr,
  output rv_pkg::prot_t     arprot,
  input  logic              rvalid,
  output logic              rready,
  input  rv_pkg::word_t     rdata,
  input  rv_pkg::resp_t     rresp
);
  typedef enum logic [1:0] {
    bus_idle,
    bus_write,
    bus_read
  } bus_state_t;

  bus_state_t state;
  logic b_hs, r_hs;

  function automatic logic resp_fault(input rv_pkg::resp_t resp);
    return resp != `RV_RESP_OKAY && resp != `RV_RESP_EXOKAY;
  endfunction

  assign b_hs = bvalid && bready;
  assign r_hs = rvalid && rready;
  assign done = b_hs || r_hs; // one cycle, ready drops right after
  assign fault = (b_hs && resp_fault(bresp)) || (r_hs && resp_fault(rresp));
  assign rsp_data = rdata;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= bus_idle;
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      bready <= 1'b0;
      arvalid <= 1'b0;
      rready <= 1'b0;
    end else begin
      case (state)
        bus_idle: begin
          if (req && write) begin
            awvalid <= 1'b1;
            wvalid <= 1'b1;
            state <= bus_write;
          end else if (req) begin
            arvalid <= 1'b1;
            state <= bus_read;
          end
        end
        bus_write: begin
          if (awready) awvalid <= 1'b0; // address and data retire independently
          if (wready) wvalid <= 1'b0;
          if (!awvalid && !wvalid && !bready) bready <= 1'b1;
          if (b_hs) begin
            bready <= 1'b0;
            state <= bus_idle;
          end
        end
        bus_read: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
          end
          if (r_hs) begin
            rready <= 1'b0;
            state <= bus_idle;
          end
        end
        default: state <= bus_idle;
      endcase
    end
  end

  // payload captured once per request
  always_ff @(posedge clk) begin
    if (state == bus_idle && req) begin
      awaddr <= addr;
      awprot <= prot;
      wdata <= cpu_wdata;
      wstrb <= cpu_wstrb;
      araddr <= addr;
      arprot <= prot;
    end
  end

endmodule

/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// privileged instruction access
`define RV_INST_PROT 3'b101
// unprivileged data access
`define RV_DATA_PROT 3'b000

`define RV_RESP_OKAY 2'b00
`define RV_RESP_EXOKAY 2'b01

`endif

/* rv_core.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core (
  input  logic               clk,
  input  logic               reset,
  input  logic               done,
  input  logic               fault,
  input  rv_pkg::word_t      rsp_data,
  output logic               req,
  output logic               write,
  output rv_pkg::word_t      addr,
  output rv_pkg::word_t      wdata,
  output rv_pkg::prot_t      prot,
  output rv_pkg::strb_t      wstrb,
  output logic               trap,
  output rv_pkg::trap_code_t trap_code
);
  localparam rv_pkg::trap_code_t trap_mem = 2'd0;
  localparam rv_pkg::trap_code_t trap_illegal = 2'd1;
  localparam rv_pkg::trap_code_t trap_ecall = 2'd2;
  localparam rv_pkg::trap_code_t trap_ebreak = 2'd3;

  rv_pkg::cpu_state_t state;
  rv_pkg::word_t pc;
  rv_pkg::word_t instr;
  rv_pkg::word_t regs [32];

  rv_pkg::reg_idx_t rd, rs1, rs2;
  rv_pkg::funct3_t funct3;
  rv_pkg::word_t imm;
  logic alt, use_imm, is_lui, is_auipc, is_alu;
  logic is_load, is_store, is_ecall, is_ebreak, illegal;

  rv_pkg::word_t rs1_val, rs2_val, alu_a, alu_b, alu_result;
  rv_pkg::funct3_t alu_f3;
  logic alu_alt;
  rv_pkg::word_t lane, load_val, store_data;
  rv_pkg::strb_t store_strb;
  logic misaligned, exec_trap;
  rv_pkg::trap_code_t exec_code;

  rv_decode u_decode (
    .instr, .rd, .rs1, .rs2, .funct3, .alt, .imm, .use_imm, .is_lui, .is_auipc,
    .is_alu, .is_load, .is_store, .is_ecall, .is_ebreak, .illegal
  );

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  // address and auipc go through the adder
  assign alu_a = is_auipc ? pc : rs1_val;
  assign alu_b = use_imm ? imm : rs2_val;
  assign alu_f3 = is_alu ? funct3 : 3'b000;
  assign alu_alt = is_alu && alt && (!use_imm || funct3 == 3'b101);

  rv_alu u_alu (.funct3(alu_f3), .alt(alu_alt), .a(alu_a), .b(alu_b), .result(alu_result));

  assign lane = rsp_data >> {addr[1:0], 3'b000}; // addressed bytes down to bit 0

  always_comb begin
    case (funct3)
      3'b000: load_val = {{24{lane[7]}}, lane[7:0]};
      3'b001: load_val = {{16{lane[15]}}, lane[15:0]};
      3'b100: load_val = {24'b0, lane[7:0]};
      3'b101: load_val = {16'b0, lane[15:0]};
      default: load_val = lane;
    endcase
  end

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        store_data = {4{rs2_val[7:0]}};
        store_strb = 4'b0001 << alu_result[1:0];
        misaligned = 1'b0;
      end
      2'b01: begin
        store_data = {2{rs2_val[15:0]}};
        store_strb = 4'b0011 << alu_result[1:0];
        misaligned = alu_result[0];
      end
      default: begin
        store_data = rs2_val;
        store_strb = 4'b1111;
        misaligned = |alu_result[1:0];
      end
    endcase
  end

  always_comb begin
    exec_trap = 1'b1;
    exec_code = trap_illegal;
    if (illegal || (is_load && rd == '0)) exec_code = trap_illegal; // no loads into x0
    else if (is_ecall) exec_code = trap_ecall;
    else if (is_ebreak) exec_code = trap_ebreak;
    else if ((is_load || is_store) && misaligned) exec_code = trap_mem;
    else exec_trap = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= rv_pkg::fetch;
      pc <= `RV_RESET_PC;
      req <= 1'b0;
      trap <= 1'b0;
      trap_code <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      req <= 1'b0;
      case (state)
        rv_pkg::fetch: begin
          req <= 1'b1;
          state <= rv_pkg::fetch_wait;
        end
        rv_pkg::fetch_wait: begin
          if (done && fault) begin
            trap <= 1'b1;
            trap_code <= trap_mem;
            state <= rv_pkg::trapped;
          end else if (done) begin
            state <= rv_pkg::execute;
          end
        end
        rv_pkg::execute: begin
          if (exec_trap) begin
            trap <= 1'b1;
            trap_code <= exec_code;
            state <= rv_pkg::trapped;
          end else if (is_load || is_store) begin
            req <= 1'b1;
            state <= rv_pkg::mem_wait;
          end else begin
            if (rd != '0) regs[rd] <= is_lui ? imm : alu_result;
            pc <= pc + 32'd4;
            state <= rv_pkg::fetch;
          end
        end
        rv_pkg::mem_wait: begin
          if (done && fault) begin
            trap <= 1'b1;
            trap_code <= trap_mem;
            state <= rv_pkg::trapped;
          end else if (done) begin
            if (is_load) regs[rd] <= load_val;
            pc <= pc + 32'd4;
            state <= rv_pkg::fetch;
          end
        end
        rv_pkg::trapped: state <= rv_pkg::trapped; // held until reset
        default: state <= rv_pkg::fetch;
      endcase
    end
  end

  // request payload and instruction latch
  always_ff @(posedge clk) begin
    if (state == rv_pkg::fetch) begin
      write <= 1'b0;
      addr <= pc;
      prot <= `RV_INST_PROT;
      wstrb <= '0;
    end
    if (state == rv_pkg::fetch_wait && done) instr <= rsp_data;
    if (state == rv_pkg::execute) begin
      write <= is_store;
      addr <= alu_result;
      prot <= `RV_DATA_PROT;
      wdata <= store_data;
      wstrb <= is_store ? store_strb : '0;
    end
  end

endmodule

/* rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
  input  rv_pkg::word_t    instr,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::funct3_t  funct3,
  output logic             alt,
  output rv_pkg::word_t    imm,
  output logic             use_imm,
  output logic             is_lui,
  output logic             is_auipc,
  output logic             is_alu,
  output logic             is_load,
  output logic             is_store,
  output logic             is_ecall,
  output logic             is_ebreak,
  output logic             illegal
);
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic imm_ok, reg_ok;

  assign opcode = instr[6:0];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign funct3 = instr[14:12];
  assign alt = instr[30]; // sub / sra select

  // shift immediates only allow srai as the alternate form
  assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                  (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) : 1'b1;
  assign reg_ok = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign is_lui = opcode == op_lui;
  assign is_auipc = opcode == op_auipc;
  assign is_alu = (opcode == op_imm && imm_ok) || (opcode == op_reg && reg_ok);
  assign is_load = opcode == op_load && funct3 != 3'b011 && funct3[2:1] != 2'b11;
  assign is_store = opcode == op_store && funct3[2] == 1'b0 && funct3[1:0] != 2'b11;
  assign is_ecall = instr == 32'h0000_0073;
  assign is_ebreak = instr == 32'h0010_0073;
  assign use_imm = opcode != op_reg;

  // branches, jumps, fence and csr land here too
  assign illegal = !(is_lui || is_auipc || is_alu || is_load || is_store ||
                     is_ecall || is_ebreak);

  always_comb begin
    case (opcode)
      op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_lui, op_auipc: imm = {instr[31:12], 12'b0};
      default: imm = {{20{instr[31]}}, instr[31:20]}; // i-type
    endcase
  end

endmodule

/* rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t; // data, address or instruction
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] strb_t; // one bit per byte lane
  typedef logic [2:0] prot_t;
  typedef logic [1:0] resp_t;

  // trap causes
  // 0 memory fault
  // 1 illegal instruction or load into x0
  // 2 ecall
  // 3 ebreak
  typedef logic [1:0] trap_code_t;

  // one instruction at a time
  typedef enum logic [2:0] {
    fetch,
    fetch_wait,
    execute,
    mem_wait,
    trapped
  } cpu_state_t;

endpackage

/* rv_properties.sv */
`timescale 1ns/1ns

module rv_properties (
  input logic          clk,
  input logic          reset,
  input logic          awvalid,
  input logic          awready,
  input rv_pkg::word_t awaddr,
  input rv_pkg::prot_t awprot,
  input logic          wvalid,
  input logic          wready,
  input rv_pkg::word_t wdata,
  input rv_pkg::strb_t wstrb,
  input logic          bvalid,
  input logic          bready,
  input logic          arvalid,
  input logic          arready,
  input rv_pkg::word_t araddr,
  input rv_pkg::prot_t arprot,
  input logic          rvalid,
  input logic          rready,
  input logic          done
);
  // valid and payload held until accepted
  aw_hold: assert property (@(posedge clk) disable iff (!reset)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awprot))
    else $error("awvalid dropped or payload changed before awready");
  w_hold: assert property (@(posedge clk) disable iff (!reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("wvalid dropped or payload changed before wready");
  ar_hold: assert property (@(posedge clk) disable iff (!reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot))
    else $error("arvalid dropped or payload changed before arready");

  no_overlap: assert property (@(posedge clk) disable iff (!reset) !(arvalid && awvalid))
    else $error("read and write address valid at the same time");

  // response only once the address and data phases are over
  done_hs: assert property (@(posedge clk) disable iff (!reset)
    done |-> (bvalid && bready && !awvalid && !wvalid) ||
             (rvalid && rready && !arvalid))
    else $error("done before the address or data handshake completed");

endmodule

bind rv_axi_master rv_properties props0 (
  .clk(clk), .reset(reset), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
  .awprot(awprot), .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
  .bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
  .araddr(araddr), .arprot(arprot), .rvalid(rvalid), .rready(rready), .done(done)
);

/* rv_top.sv */
`timescale 1ns/1ns

module rv_top (
  input  logic               clk,
  input  logic               reset,
  output logic               awvalid,
  input  logic               awready,
  output rv_pkg::word_t      awaddr,
  output rv_pkg::prot_t      awprot,
  output logic               wvalid,
  input  logic               wready,
  output rv_pkg::word_t      wdata,
  output rv_pkg::strb_t      wstrb,
  input  logic               bvalid,
  output logic               bready,
  input  rv_pkg::resp_t      bresp,
  output logic               arvalid,
  input  logic               arready,
  output rv_pkg::word_t      araddr,
  output rv_pkg::prot_t      arprot,
  input  logic               rvalid,
  output logic               rready,
  input  rv_pkg::word_t      rdata,
  input  rv_pkg::resp_t      rresp,
  output logic               trap,
  output rv_pkg::trap_code_t trap_code
);
  logic mem_req, mem_write, mem_done, mem_fault;
  rv_pkg::word_t mem_addr, mem_wdata, mem_rdata;
  rv_pkg::prot_t mem_prot;
  rv_pkg::strb_t mem_wstrb;

  rv_core u_core (
    .clk, .reset, .done(mem_done), .fault(mem_fault), .rsp_data(mem_rdata),
    .req(mem_req), .write(mem_write), .addr(mem_addr), .wdata(mem_wdata),
    .prot(mem_prot), .wstrb(mem_wstrb), .trap, .trap_code
  );

  rv_axi_master u_axi (
    .clk, .reset, .req(mem_req), .write(mem_write), .addr(mem_addr), .prot(mem_prot),
    .cpu_wdata(mem_wdata), .cpu_wstrb(mem_wstrb), .done(mem_done), .fault(mem_fault),
    .rsp_data(mem_rdata), .awvalid, .awready, .awaddr, .awprot, .wvalid, .wready,
    .wdata, .wstrb, .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .arprot,
    .rvalid, .rready, .rdata, .rresp
  );

endmodule

/* tb_rv_top.sv */
`timescale 1ns/1ns
`include "rv_cfg.svh"

module tb_rv_top;
  logic clk = 1'b0;
  logic reset = 1'b0;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, trap;
  rv_pkg::word_t awaddr, wdata, araddr, rdata;
  rv_pkg::prot_t awprot, arprot;
  rv_pkg::strb_t wstrb;
  rv_pkg::resp_t bresp, rresp;
  rv_pkg::trap_code_t trap_code;

  integer seed = 32'h32b8;
  string test_name;
  logic [31:0] mem [4096]; // slave memory with word 0 at address 0
  logic [31:0] mm [4096];  // model's own copy
  logic [31:0] exp_addr[$], exp_data[$];
  logic [3:0] exp_strb[$];
  logic [31:0] acc_addrs[$];
  logic [1:0] exp_trap;
  logic [29:0] err_word;
  int n_prog, n_steps, wr_idx, wd_count, wd_limit;
  bit heavy, running;

  rv_top dut0 (.*);

  always #5 clk = ~clk;

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int delay();
    if (heavy) return 2 + rnd(2); // mostly stalled
    return rnd(4);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] masked(input logic [31:0] d, input logic [3:0] st);
    logic [31:0] m;
    for (int j = 0; j < 4; j++) m[8*j +: 8] = st[j] ? d[8*j +: 8] : 8'h00;
    return m;
  endfunction

  // instruction encoders for the rv32i formats
  function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction
  function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction
  function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction
  function automatic logic [31:0] enc_u(input logic [31:0] imm, rd, op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[n_prog] = w;
    n_prog++;
  endtask

  // kind 0 plain, 1 illegal opcode, 2 ebreak, 3 bus error, 4 back-pressure
  task automatic gen_program(input int kind);
    int bad_pos, choice, f3, off, r;
    int load_f3 [5] = '{0, 1, 2, 4, 5};
    logic [31:0] imm;
    for (int i = 0; i < 4096; i++) mem[i] = 32'h5a5a_0000 ^ (i * 4); // address based fill
    for (int i = 0; i < 256; i++) mem[1024 + i] = $random(seed);
    n_prog = 0;
    acc_addrs.delete();
    emit(enc_u(1, 31, 7'h37)); // x31 -> data region 0x1000
    emit(enc_u(2, 30, 7'h37)); // x30 -> dump region 0x2000
    for (int k = 1; k < 16; k++) begin
      emit(enc_u(rnd(1 << 20), k, 7'h37));
      emit(enc_i(rnd(4096), k, 0, k, 7'h13));
    end
    bad_pos = rnd(40);
    for (int i = 0; i < 40; i++) begin
      choice = rnd(8);
      f3 = rnd(8);
      if (kind == 1 && i == bad_pos) emit(32'h0000_006f); // jal is not supported
      else begin
        case (choice)
          1: begin
            if (f3 == 1) imm = rnd(32);
            else if (f3 == 5) imm = rnd(32) | (rnd(2) ? 32'h400 : 32'h0);
            else imm = rnd(4096);
            emit(enc_i(imm, rnd(16), f3, rnd(16), 7'h13));
          end
          2: emit(enc_u(rnd(1 << 20), rnd(16), 7'h37));
          3: emit(enc_u(rnd(1 << 20), rnd(16), 7'h17));
          4, 5: begin
            f3 = load_f3[rnd(5)];
            off = rnd(1024) & ~((1 << (f3 % 4)) - 1);
            emit(enc_i(off, 31, f3, 1 + rnd(15), 7'h03));
            acc_addrs.push_back(32'h1000 + off);
          end
          6: begin
            f3 = rnd(3);
            off = rnd(1024) & ~((1 << f3) - 1);
            emit(enc_s(off, rnd(16), 31, f3));
            acc_addrs.push_back(32'h1000 + off);
          end
          default: emit(enc_r(((f3 == 0 || f3 == 5) && rnd(2)) ? 32'h20 : 0,
                              rnd(16), rnd(16), f3, rnd(16)));
        endcase
      end
      if (i % 10 == 9) begin
        for (int k = 0; k < 4; k++) begin
          r = rnd(16);
          emit(enc_s(4 * r, r, 30, 2));
        end
      end
    end
    for (int k = 0; k < 16; k++) emit(enc_s(4 * k, k, 30, 2)); // final register dump
    emit(kind == 2 ? 32'h0010_0073 : 32'h0000_0073);
    err_word = '1;
    if (kind == 3 && acc_addrs.size() > 0) err_word = acc_addrs[rnd(acc_addrs.size())][31:2];
  endtask

  // reference isa model that predicts every write and the final trap
  task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] pc, ins, a, b, ad, lane, d;
    logic [3:0] st;
    logic [2:0] f3;
    bit fin;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 4096; i++) mm[i] = mem[i];
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    pc = `RV_RESET_PC;
    fin = 0;
    n_steps = 0;
    while (!fin) begin
      ins = mm[pc[13:2]];
      f3 = ins[14:12];
      a = r[ins[19:15]];
      b = r[ins[24:20]];
      n_steps++;
      case (ins[6:0])
        7'h37: r[ins[11:7]] = {ins[31:12], 12'h000};
        7'h17: r[ins[11:7]] = pc + {ins[31:12], 12'h000};
        7'h13: r[ins[11:7]] = alu_ref(f3, f3 == 5 && ins[30], a,
                                      {{20{ins[31]}}, ins[31:20]});
        7'h33: r[ins[11:7]] = alu_ref(f3, ins[30], a, b);
        7'h03: begin
          ad = a + {{20{ins[31]}}, ins[31:20]};
          if (ins[11:7] == 0) begin
            exp_trap = 2'd1;
            fin = 1;
          end else if ((f3[1:0] == 1 && ad[0]) || (f3[1:0] == 2 && ad[1:0] != 0) ||
                       ad[31:2] == err_word) begin
            exp_trap = 2'd0;
            fin = 1;
          end else begin
            lane = mm[ad[13:2]] >> (8 * ad[1:0]);
            case (f3)
              3'd0: r[ins[11:7]] = {{24{lane[7]}}, lane[7:0]};
              3'd1: r[ins[11:7]] = {{16{lane[15]}}, lane[15:0]};
              3'd4: r[ins[11:7]] = {24'h0, lane[7:0]};
              3'd5: r[ins[11:7]] = {16'h0, lane[15:0]};
              default: r[ins[11:7]] = lane;
            endcase
          end
        end
        7'h23: begin
          ad = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          st = (f3 == 0) ? 4'b0001 << ad[1:0] : (f3 == 1) ? 4'b0011 << ad[1:0] : 4'b1111;
          d = (f3 == 0) ? {4{b[7:0]}} : (f3 == 1) ? {2{b[15:0]}} : b;
          if ((f3 == 1 && ad[0]) || (f3 == 2 && ad[1:0] != 0) || ad[31:2] == err_word) begin
            exp_trap = 2'd0;
            fin = 1;
          end else begin
            exp_addr.push_back(ad);
            exp_data.push_back(masked(d, st));
            exp_strb.push_back(st);
            for (int j = 0; j < 4; j++) if (st[j]) mm[ad[13:2]][8*j +: 8] = d[8*j +: 8];
          end
        end
        default: begin
          exp_trap = (ins == 32'h73) ? 2'd2 : (ins == 32'h0010_0073) ? 2'd3 : 2'd1;
          fin = 1;
        end
      endcase
      r[0] = '0;
      if (!fin) pc = pc + 4;
    end
  endtask

  // axi4-lite slave with random ready and response delays
  int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  bit r_pend, b_pend, aw_got, w_got, b_err;
  logic [31:0] r_a, aw_a, w_d, next_fetch;
  logic [3:0] w_s;

  always @(posedge clk) begin
    if (!reset) begin
      arready <= 0;
      rvalid <= 0;
      awready <= 0;
      wready <= 0;
      bvalid <= 0;
      rdata <= '0;
      rresp <= '0;
      bresp <= '0;
      r_pend = 0;
      b_pend = 0;
      aw_got = 0;
      w_got = 0;
      ar_cnt = delay();
      aw_cnt = delay();
      w_cnt = delay();
      wr_idx = 0;
      next_fetch = `RV_RESET_PC;
    end else begin
      if (arvalid && arready) begin
        arready <= 0;
        r_a = araddr;
        if (araddr < 32'h1000) begin
          check_eq("fetch address", next_fetch, araddr);
          check_eq("fetch prot", `RV_INST_PROT, arprot);
          next_fetch = next_fetch + 4;
        end else check_eq("load prot", `RV_DATA_PROT, arprot);
        r_pend = 1;
        r_cnt = delay();
        ar_cnt = delay();
      end else if (arvalid) begin
        if (ar_cnt == 0) arready <= 1;
        else ar_cnt--;
      end
      if (rvalid && rready) rvalid <= 0;
      else if (r_pend && !rvalid) begin
        if (r_cnt == 0) begin
          rvalid <= 1;
          rdata <= mem[r_a[13:2]];
          rresp <= (r_a[31:2] == err_word) ? 2'b10 : 2'b00;
          r_pend = 0;
        end else r_cnt--;
      end
      if (awvalid && awready) begin
        awready <= 0;
        aw_a = awaddr;
        check_eq("store prot", `RV_DATA_PROT, awprot);
        aw_got = 1;
        aw_cnt = delay();
      end else if (awvalid) begin
        if (aw_cnt == 0) awready <= 1;
        else aw_cnt--;
      end
      if (wvalid && wready) begin
        wready <= 0;
        w_d = wdata;
        w_s = wstrb;
        w_got = 1;
        w_cnt = delay();
      end else if (wvalid) begin
        if (w_cnt == 0) wready <= 1;
        else w_cnt--;
      end
      if (aw_got && w_got) begin
        aw_got = 0;
        w_got = 0;
        b_pend = 1;
        b_cnt = delay();
        b_err = aw_a[31:2] == err_word;
        if (!b_err) begin
          check_true(wr_idx < exp_addr.size(), "store issued beyond the predicted writes");
          check_eq("write address", exp_addr[wr_idx], aw_a);
          check_eq("write strobe", exp_strb[wr_idx], w_s);
          check_eq("write data", exp_data[wr_idx], masked(w_d, w_s));
          wr_idx++;
          for (int j = 0; j < 4; j++) if (w_s[j]) mem[aw_a[13:2]][8*j +: 8] = w_d[8*j +: 8];
        end
      end
      if (bvalid && bready) bvalid <= 0;
      else if (b_pend && !bvalid) begin
        if (b_cnt == 0) begin
          bvalid <= 1;
          bresp <= b_err ? 2'b10 : 2'b00;
          b_pend = 0;
        end else b_cnt--;
      end
    end
  end

  // watchdog allows 20 cycles per executed instruction
  always @(posedge clk) begin
    if (running) begin
      wd_count++;
      if (wd_count > wd_limit) begin
        $display("%s: no trap after %0d cycles", test_name, wd_count);
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
  end

  task automatic run_test(input string name, input int kind);
    test_name = name;
    heavy = kind == 4;
    @(posedge clk);
    reset <= 1'b0;
    gen_program(kind);
    run_model();
    repeat (5) @(posedge clk);
    check_true(!awvalid && !wvalid && !arvalid && !bready && !rready,
               "bus valid or ready high during reset");
    check_true(!trap, "trap high during reset");
    reset <= 1'b1;
    wd_count = 0;
    wd_limit = (n_steps + 4) * 20;
    running = 1;
    while (!trap) @(posedge clk);
    running = 0;
    check_eq("trap code", exp_trap, trap_code);
    check_eq("write count", exp_addr.size(), wr_idx);
    repeat (20) begin
      @(posedge clk);
      check_true(!arvalid && !awvalid && trap, "bus request or trap change after trap");
    end
  endtask

  initial begin
    awready = 0;
    wready = 0;
    bvalid = 0;
    bresp = '0;
    arready = 0;
    rvalid = 0;
    rdata = '0;
    rresp = '0;
    running = 0;
    heavy = 0;
    err_word = '1;
    for (int t = 0; t < 4; t++) run_test("alu_mem", 0);
    run_test("illegal", 1);
    run_test("ebreak", 2);
    for (int t = 0; t < 3; t++) run_test("bus_error", 3);
    for (int t = 0; t < 2; t++) run_test("backpressure", 4);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
